// ==== Bender.yml ====
package:
  name: usb_rx

export_include_dirs:
  - .

sources:
  - usb_rx_pkg.sv
  - usb_rx_line_decoder.sv
  - usb_rx_shift_reg.sv
  - usb_rx_crc_check.sv
  - usb_rx_control_fsm.sv
  - usb_rx.sv
  - target: test
    files:
      - tb_usb_rx.sv

// ==== tb_usb_rx.sv ====
// Testbench for the USB receive path: line driver, CRC builders, monitor and directed tests.
`timescale 1ns/1ns
`include "usb_rx_consts.svh"

module tb_usb_rx;

  localparam usb_rx_pkg::dev_addr_t MY_ADDR = 7'h2A;
  localparam int TIMEOUT = 400;

  logic clk;
  logic n_rst;
  logic d_plus;
  logic d_minus;
  usb_rx_pkg::dev_addr_t dev_addr;
  usb_rx_pkg::packet_kind_t rx_pid;
  usb_rx_pkg::byte_t rx_data;
  logic rx_data_valid;

  usb_rx_pkg::byte_t pkt[$];          // Packet under construction, PID first.
  usb_rx_pkg::byte_t expect_data[$];
  usb_rx_pkg::byte_t data_seen[$];
  usb_rx_pkg::packet_kind_t reports[$];
  int errors;
  int seed;

  usb_rx i_usb_rx (
    .clk           (clk),
    .n_rst         (n_rst),
    .d_plus        (d_plus),
    .d_minus       (d_minus),
    .dev_addr      (dev_addr),
    .rx_pid        (rx_pid),
    .rx_data       (rx_data),
    .rx_data_valid (rx_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Strobes sampled mid-cycle.
  always @(negedge clk) begin
    if (rx_pid != usb_rx_pkg::pkt_idle) reports.push_back(rx_pid);
    if (rx_data_valid) data_seen.push_back(rx_data);
  end

  // ############################################################
  // Checks and waits
  // ############################################################
  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Value mismatch in %s.", test);
    end
  endtask

  task automatic expect_report(input string test, input usb_rx_pkg::packet_kind_t kind);
    int cycles;
    cycles = 0;
    while (reports.size() == 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (reports.size() == 0) begin
      errors++;
      $display("%s: no packet report arrived within %0d cycles.", test, TIMEOUT);
      $display("Simulation failed");
      $fatal(1, "Timeout in %s.", test);
    end
    check_value(test, kind, reports.pop_front());
  endtask

  task automatic expect_quiet(input string test);
    for (int i = 0; i < TIMEOUT; i++) @(posedge clk);
    check_value({test, " reports"}, 0, reports.size());
  endtask

  task automatic check_payload(input string test);
    check_value({test, " byte count"}, expect_data.size(), data_seen.size());
    foreach (expect_data[i]) check_value(test, expect_data[i], data_seen[i]);
  endtask

  // ############################################################
  // Line driver and packet builders
  // ############################################################
  task automatic drive_line(input logic dp, input logic dm);
    @(posedge clk);
    d_plus <= dp;
    d_minus <= dm;
    repeat (`USB_CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  // Sync, pkt with trim_bits dropped from the end, then SE0 SE0 J.
  task automatic send_packet(input int trim_bits);
    logic bits[$];
    logic [7:0] b;
    logic level;
    int ones;
    int nbits;
    reports = {};
    data_seen = {};
    b = `USB_SYNC_BYTE;
    for (int i = 0; i < 8; i++) bits.push_back(b[i]);
    foreach (pkt[n]) begin
      b = pkt[n];
      for (int i = 0; i < 8; i++) bits.push_back(b[i]);
    end
    nbits = bits.size() - trim_bits;
    level = 1'b1;
    ones = 0;
    for (int i = 0; i < nbits; i++) begin
      if (!bits[i]) level = ~level;  // NRZI: zero toggles.
      drive_line(level, ~level);
      ones = bits[i] ? ones + 1 : 0;
      if (ones == `USB_MAX_ONES) begin
        level = ~level;  // Stuffed zero.
        drive_line(level, ~level);
        ones = 0;
      end
    end
    drive_line(1'b0, 1'b0);
    drive_line(1'b0, 1'b0);
    drive_line(1'b1, 1'b0);
  endtask

  task automatic build_token(input usb_rx_pkg::byte_t pid, input logic [6:0] addr,
                             input logic [3:0] endp);
    logic [10:0] field;
    logic [4:0] crc;
    logic fb;
    field = {endp, addr};
    crc = '1;
    for (int i = 0; i < 11; i++) begin
      fb = crc[4] ^ field[i];
      crc = {crc[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
    end
    crc = ~crc;
    pkt = {};
    pkt.push_back(pid);
    pkt.push_back(field[7:0]);
    pkt.push_back({crc[0], crc[1], crc[2], crc[3], crc[4], field[10:8]});  // MSB sent first.
  endtask

  task automatic append_crc16();
    logic [15:0] crc;
    logic [7:0] b;
    logic fb;
    crc = '1;
    for (int n = 1; n < pkt.size(); n++) begin
      b = pkt[n];
      for (int i = 0; i < 8; i++) begin
        fb = crc[15] ^ b[i];
        crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
    end
    crc = ~crc;
    for (int i = 0; i < 8; i++) b[i] = crc[15 - i];
    pkt.push_back(b);
    for (int i = 0; i < 8; i++) b[i] = crc[7 - i];
    pkt.push_back(b);
  endtask

  task automatic build_random_data(input usb_rx_pkg::byte_t pid);
    usb_rx_pkg::byte_t b;
    int len;
    len = 1 + ($unsigned($random(seed)) % 8);
    pkt = {};
    pkt.push_back(pid);
    for (int i = 0; i < len; i++) begin
      b = $random(seed);
      pkt.push_back(b);
    end
  endtask

  task automatic run_data(input string test);
    append_crc16();
    expect_data = {};
    // Payload only, without PID and CRC bytes.
    for (int i = 1; i < pkt.size() - 2; i++) expect_data.push_back(pkt[i]);
    send_packet(0);
    expect_report(test, usb_rx_pkg::pkt_data);
    check_payload(test);
  endtask

  // ############################################################
  // Directed tests
  // ############################################################
  task automatic test_tokens();
    build_token(`USB_PID_IN, MY_ADDR, 4'h3);
    send_packet(0);
    expect_report("in_token", usb_rx_pkg::pkt_in);
    build_token(`USB_PID_OUT, MY_ADDR, 4'h0);
    send_packet(0);
    expect_report("out_token", usb_rx_pkg::pkt_out);
    build_token(`USB_PID_IN, 7'h15, 4'h1);
    send_packet(0);
    expect_quiet("other_addr");
  endtask

  task automatic test_data();
    build_random_data(`USB_PID_DATA0);
    run_data("data0");
    build_random_data(`USB_PID_DATA1);
    run_data("data1");
  endtask

  task automatic test_stuffing();
    pkt = {`USB_PID_DATA0, 8'hFF, 8'h7F, 8'hFF, 8'h3F, 8'hFF};
    run_data("stuffing");
  endtask

  task automatic test_bad_crc();
    build_random_data(`USB_PID_DATA0);
    append_crc16();
    pkt[1] = pkt[1] ^ 8'h08;  // Flipped after the CRC.
    send_packet(0);
    expect_report("data_bad_crc", usb_rx_pkg::pkt_bad);
    build_token(`USB_PID_OUT, MY_ADDR, 4'h2);
    pkt[2] = pkt[2] ^ 8'h80;
    send_packet(0);
    expect_report("token_bad_crc", usb_rx_pkg::pkt_bad);
  endtask

  task automatic test_handshakes();
    pkt = {`USB_PID_ACK};
    send_packet(0);
    expect_report("ack", usb_rx_pkg::pkt_ack);
    pkt = {`USB_PID_NAK};
    send_packet(0);
    expect_report("nak", usb_rx_pkg::pkt_nak);
    pkt = {8'hD3};  // Check nibble does not match.
    send_packet(0);
    expect_quiet("bad_pid");
    pkt = {`USB_PID_ACK};
    send_packet(0);
    expect_report("ack_after_bad_pid", usb_rx_pkg::pkt_ack);
  endtask

  task automatic test_mid_byte_eop();
    pkt = {`USB_PID_DATA0, 8'h12, 8'h34, 8'h56};
    append_crc16();
    send_packet(4);
    expect_report("mid_byte_eop", usb_rx_pkg::pkt_bad);
    build_token(`USB_PID_OUT, MY_ADDR, 4'h5);
    send_packet(0);
    expect_report("token_after_eop", usb_rx_pkg::pkt_out);
  endtask

  initial begin
    n_rst = 1'b0;
    d_plus = 1'b1;  // Idle J.
    d_minus = 1'b0;
    dev_addr = MY_ADDR;
    errors = 0;
    seed = 32'h4077_ce89;
    repeat (4) @(posedge clk);
    n_rst <= 1'b1;
    repeat (4) @(posedge clk);
    test_tokens();
    test_data();
    test_stuffing();
    test_bad_crc();
    test_handshakes();
    test_mid_byte_eop();
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== usb_rx.f ====
+incdir+.
usb_rx_pkg.sv
usb_rx_line_decoder.sv
usb_rx_shift_reg.sv
usb_rx_crc_check.sv
usb_rx_control_fsm.sv
usb_rx.sv
tb_usb_rx.sv

// ==== usb_rx.sv ====
// Top of the USB full-speed receive path.
`timescale 1ns/1ns

module usb_rx (
  input  logic                     clk,
  input  logic                     n_rst,
  input  logic                     d_plus,
  input  logic                     d_minus,
  input  usb_rx_pkg::dev_addr_t    dev_addr,
  output usb_rx_pkg::packet_kind_t rx_pid,
  output usb_rx_pkg::byte_t        rx_data,
  output logic                     rx_data_valid
);

  usb_rx_pkg::rx_bit_t rx_bit;
  usb_rx_pkg::sr_word_t sr_val;
  logic byte_done;
  logic clear_crc;
  logic pass_5_bit;
  logic pass_16_bit;

  usb_rx_line_decoder i_line_decoder (
    .clk     (clk),
    .n_rst   (n_rst),
    .d_plus  (d_plus),
    .d_minus (d_minus),
    .rx_bit  (rx_bit)
  );

  usb_rx_shift_reg i_shift_reg (
    .clk       (clk),
    .n_rst     (n_rst),
    .rx_bit    (rx_bit),
    .sr_val    (sr_val),
    .byte_done (byte_done)
  );

  usb_rx_crc_check i_crc_check (
    .clk         (clk),
    .n_rst       (n_rst),
    .rx_bit      (rx_bit),
    .clear_crc   (clear_crc),
    .pass_5_bit  (pass_5_bit),
    .pass_16_bit (pass_16_bit)
  );

  usb_rx_control_fsm i_control_fsm (
    .clk           (clk),
    .n_rst         (n_rst),
    .rx_bit        (rx_bit),
    .sr_val        (sr_val),
    .byte_done     (byte_done),
    .pass_5_bit    (pass_5_bit),
    .pass_16_bit   (pass_16_bit),
    .dev_addr      (dev_addr),
    .clear_crc     (clear_crc),
    .rx_pid        (rx_pid),
    .rx_data       (rx_data),
    .rx_data_valid (rx_data_valid)
  );

endmodule

// ==== usb_rx_consts.svh ====
// Macros for USB receive: PID codes, sync byte, CRC residues and bit timing.
`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// ############################################################
// Bit timing
// ############################################################
`define USB_CLKS_PER_BIT 8
`define USB_SAMPLE_POINT (`USB_CLKS_PER_BIT / 2)  // Mid-bit.
`define USB_MAX_ONES 6

// KJKJKJKK on the wire, decoded LSB first.
`define USB_SYNC_BYTE 8'h80

// PID bytes as received, check nibble on top.
`define USB_PID_OUT   8'hE1
`define USB_PID_IN    8'h69
`define USB_PID_DATA0 8'hC3
`define USB_PID_DATA1 8'h4B
`define USB_PID_ACK   8'hD2
`define USB_PID_NAK   8'h5A

// Register contents after a good packet.
`define USB_CRC5_RESIDUE  5'b01100
`define USB_CRC16_RESIDUE 16'h800D

`endif

// ==== usb_rx_control_fsm.sv ====
// Packet decoder FSM with PID check, address match, CRC check and payload output.
`timescale 1ns/1ns
`include "usb_rx_consts.svh"

module usb_rx_control_fsm (
  input  logic                     clk,
  input  logic                     n_rst,
  input  usb_rx_pkg::rx_bit_t      rx_bit,
  input  usb_rx_pkg::sr_word_t     sr_val,
  input  logic                     byte_done,
  input  logic                     pass_5_bit,
  input  logic                     pass_16_bit,
  input  usb_rx_pkg::dev_addr_t    dev_addr,
  output logic                     clear_crc,
  output usb_rx_pkg::packet_kind_t rx_pid,
  output usb_rx_pkg::byte_t        rx_data,
  output logic                     rx_data_valid
);

  typedef enum logic [3:0] {
    idle, sync, pid_wait, check_pid, token, read_token, crc5,
    data, read_data, crc16, hs_eop, report, bad
  } state_t;

  state_t state;
  state_t next_state;
  usb_rx_pkg::packet_kind_t kind_q;
  usb_rx_pkg::packet_kind_t next_kind;
  usb_rx_pkg::packet_kind_t next_rx_pid;
  usb_rx_pkg::byte_t pid;
  usb_rx_pkg::byte_t last_byte;  // Older byte at the previous strobe.
  logic mid_byte;
  logic emit;

  assign pid = sr_val[15:8];
  assign clear_crc = (state == sync) || (state == pid_wait) || (state == check_pid);
  assign emit = (state == crc16) && byte_done;  // Byte two back is payload.

  // ############################################################
  // Next state
  // ############################################################
  always_comb begin
    next_state = state;
    next_kind = kind_q;
    next_rx_pid = usb_rx_pkg::pkt_idle;
    case (state)
      idle: if (byte_done) next_state = sync;
      sync: next_state = (pid == `USB_SYNC_BYTE) ? pid_wait : idle;
      pid_wait: begin
        if (rx_bit.eop) next_state = idle;
        else if (byte_done) next_state = check_pid;
      end
      check_pid: begin
        next_state = idle;  // Unknown or bad check nibble.
        case (pid)
          `USB_PID_IN: begin
            next_state = token;
            next_kind = usb_rx_pkg::pkt_in;
          end
          `USB_PID_OUT: begin
            next_state = token;
            next_kind = usb_rx_pkg::pkt_out;
          end
          `USB_PID_DATA0, `USB_PID_DATA1: begin
            next_state = data;
            next_kind = usb_rx_pkg::pkt_data;
          end
          `USB_PID_ACK: begin
            next_state = hs_eop;
            next_kind = usb_rx_pkg::pkt_ack;
          end
          `USB_PID_NAK: begin
            next_state = hs_eop;
            next_kind = usb_rx_pkg::pkt_nak;
          end
          default: ;
        endcase
      end
      token, data: begin
        if (rx_bit.eop) next_state = bad;
        else if (byte_done) next_state = (state == token) ? read_token : read_data;
      end
      read_token: begin
        if (rx_bit.eop) next_state = bad;
        else if (byte_done) next_state = crc5;
      end
      crc5: begin
        if (byte_done) begin
          next_state = bad;  // Token too long.
        end else if (rx_bit.eop) begin
          if (mid_byte || !pass_5_bit) next_state = bad;
          else if (sr_val[6:0] == dev_addr) next_state = report;
          else next_state = idle;
        end
      end
      read_data: begin
        if (rx_bit.eop) next_state = bad;
        else if (byte_done) next_state = crc16;
      end
      crc16: begin
        if (rx_bit.eop) begin
          next_state = idle;
          next_rx_pid = (pass_16_bit && !mid_byte) ? usb_rx_pkg::pkt_data
                                                   : usb_rx_pkg::pkt_bad;
        end
      end
      hs_eop: begin
        if (byte_done) next_state = bad;
        else if (rx_bit.eop) next_state = mid_byte ? bad : report;
      end
      report: begin
        next_rx_pid = kind_q;
        next_state = idle;
      end
      bad: begin
        next_rx_pid = usb_rx_pkg::pkt_bad;
        next_state = idle;
      end
      default: next_state = idle;
    endcase
  end

  // ############################################################
  // Registers
  // ############################################################
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state <= idle;
      kind_q <= usb_rx_pkg::pkt_idle;
      rx_pid <= usb_rx_pkg::pkt_idle;
      rx_data_valid <= 1'b0;
      mid_byte <= 1'b0;
    end else begin
      state <= next_state;
      kind_q <= next_kind;
      rx_pid <= next_rx_pid;
      rx_data_valid <= emit;
      if (rx_bit.eop || byte_done) mid_byte <= 1'b0;
      else if (rx_bit.valid) mid_byte <= 1'b1;  // Partial byte pending.
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done) last_byte <= sr_val[7:0];
    if (emit) rx_data <= last_byte;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    (rx_pid != usb_rx_pkg::pkt_idle) |=> (rx_pid == usb_rx_pkg::pkt_idle));

endmodule

// ==== usb_rx_crc_check.sv ====
// Serial CRC5 and CRC16 checkers with residue compare.
`timescale 1ns/1ns
`include "usb_rx_consts.svh"

module usb_rx_crc_check (
  input  logic                clk,
  input  logic                n_rst,
  input  usb_rx_pkg::rx_bit_t rx_bit,
  input  logic                clear_crc,
  output logic                pass_5_bit,
  output logic                pass_16_bit
);

  logic [4:0] crc5;
  logic [15:0] crc16;
  logic fb5;
  logic fb16;

  assign fb5 = crc5[4] ^ rx_bit.value;
  assign fb16 = crc16[15] ^ rx_bit.value;

  // ############################################################
  // LFSRs
  // ############################################################
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      crc5 <= '1;
      crc16 <= '1;
    end else if (clear_crc) begin
      crc5 <= '1;
      crc16 <= '1;
    end else if (rx_bit.valid) begin
      // x^5 + x^2 + 1.
      crc5 <= {crc5[3:0], 1'b0} ^ (fb5 ? 5'b00101 : 5'b00000);
      // x^16 + x^15 + x^2 + 1.
      crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? 16'h8005 : 16'h0000);
    end
  end

  assign pass_5_bit = (crc5 == `USB_CRC5_RESIDUE);
  assign pass_16_bit = (crc16 == `USB_CRC16_RESIDUE);

endmodule

// ==== usb_rx_line_decoder.sv ====
// Line decoder: D+/D- synchronizer, bit sampler, NRZI decode, unstuffing and EOP.
`timescale 1ns/1ns
`include "usb_rx_consts.svh"

module usb_rx_line_decoder (
  input  logic                clk,
  input  logic                n_rst,
  input  logic                d_plus,
  input  logic                d_minus,
  output usb_rx_pkg::rx_bit_t rx_bit
);

  localparam int PHASE_W = $clog2(`USB_CLKS_PER_BIT);
  localparam int ONES_W = $clog2(`USB_MAX_ONES + 1);

  logic [1:0] sync1;  // {d_plus, d_minus}
  logic [1:0] sync2;
  logic [1:0] line_q;
  logic [PHASE_W-1:0] phase;
  logic [ONES_W-1:0] ones_cnt;
  logic [1:0] se0_cnt;
  logic sample;
  logic se0;
  logic bit_val;
  logic last_level;
  logic active;

  // ############################################################
  // Synchronizer and bit phase
  // ############################################################
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      sync1 <= 2'b10;  // Idle J.
      sync2 <= 2'b10;
      line_q <= 2'b10;
    end else begin
      sync1 <= {d_plus, d_minus};
      sync2 <= sync1;
      line_q <= sync2;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      phase <= '0;
    end else if (sync2 != line_q) begin
      phase <= '0;  // Re-phase on every transition.
    end else if (phase == PHASE_W'(`USB_CLKS_PER_BIT - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign sample = (phase == PHASE_W'(`USB_SAMPLE_POINT));
  assign se0 = (line_q == 2'b00);
  assign bit_val = (line_q[1] == last_level);  // No change is a one.

  // ############################################################
  // NRZI, unstuffing and EOP
  // ############################################################
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      rx_bit <= '0;
      last_level <= 1'b1;
      active <= 1'b0;
      se0_cnt <= '0;
      ones_cnt <= '0;
    end else begin
      rx_bit <= '0;
      if (sample) begin
        if (se0) begin
          if (se0_cnt != 2'd2) se0_cnt <= se0_cnt + 1'b1;
        end else if (se0_cnt == 2'd2) begin
          rx_bit.eop <= line_q[1];  // J closes the EOP.
          se0_cnt <= '0;
          active <= 1'b0;
          ones_cnt <= '0;
          last_level <= line_q[1];
        end else if (active || !line_q[1]) begin
          // First K wakes the receiver.
          se0_cnt <= '0;
          active <= 1'b1;
          last_level <= line_q[1];
          if (ones_cnt == ONES_W'(`USB_MAX_ONES)) begin
            ones_cnt <= '0;  // Stuffed zero dropped.
          end else begin
            rx_bit.valid <= 1'b1;
            rx_bit.value <= bit_val;
            ones_cnt <= bit_val ? ones_cnt + 1'b1 : '0;
          end
        end else begin
          se0_cnt <= '0;
        end
      end
    end
  end

  // Re-phasing never packs bit strobes closer than half a bit.
  assert property (@(posedge clk) disable iff (!n_rst)
    rx_bit.valid |=> !rx_bit.valid [*4]);

endmodule

// ==== usb_rx_pkg.sv ====
// Package with the shared vector typedefs, packet kinds and the bit-stream struct.
package usb_rx_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] dev_addr_t;
  typedef logic [15:0] sr_word_t;

  // Reported once per packet.
  typedef enum logic [2:0] {
    pkt_idle,
    pkt_data,
    pkt_out,
    pkt_in,
    pkt_ack,
    pkt_nak,
    pkt_bad
  } packet_kind_t;

  // Decoded line bit.
  typedef struct packed {
    logic valid;  // One pulse per unstuffed bit.
    logic value;
    logic eop;    // One pulse at end of packet.
  } rx_bit_t;

endpackage

// ==== usb_rx_shift_reg.sv ====
// Receive shift register with bit counter and byte strobe.
`timescale 1ns/1ns

module usb_rx_shift_reg (
  input  logic                 clk,
  input  logic                 n_rst,
  input  usb_rx_pkg::rx_bit_t  rx_bit,
  output usb_rx_pkg::sr_word_t sr_val,
  output logic                 byte_done
);

  logic [2:0] bit_cnt;

  // Newest bit enters at the top.
  always_ff @(posedge clk) begin
    if (rx_bit.valid) begin
      sr_val <= {rx_bit.value, sr_val[15:1]};
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      bit_cnt <= '0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= rx_bit.valid && (bit_cnt == 3'd7);
      if (rx_bit.eop) begin
        bit_cnt <= '0;  // Realign for the next packet.
      end else if (rx_bit.valid) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!n_rst) byte_done |=> !byte_done);

endmodule
